// ==== serv_pkg.sv ====
`default_nettype none

package serv_pkg;

   // Data word and register file geometry
   localparam int XLEN   = 32;
   localparam int REG_AW = 5;

   // Bit counter spans one 32-cycle pass
   localparam int CNT_W  = 5;

   // Core sequencing
   typedef enum logic [2:0] {
      ST_IDLE  = 3'd0,
      ST_FETCH = 3'd1,
      ST_EXEC1 = 3'd2,
      ST_MEM   = 3'd3,
      ST_EXEC2 = 3'd4
   } state_t;

   // RV32I major opcodes of the supported subset
   typedef enum logic [6:0] {
      OPC_OPIMM  = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_LUI    = 7'b0110111,
      OPC_JAL    = 7'b1101111,
      OPC_BRANCH = 7'b1100011,
      OPC_STORE  = 7'b0100011
   } opcode_t;

   // Serial ALU functions
   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_XOR = 3'd2,
      ALU_OR  = 3'd3,
      ALU_AND = 3'd4
   } alu_op_t;

endpackage

`default_nettype wire

// ==== serv_state.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_state import serv_pkg::*; (
   input  wire  clk,
   input  wire  i_rst_n,
   input  wire  i_ibus_ack,
   input  wire  i_dbus_ack,
   input  wire  i_two_stage,
   input  wire  i_store,
   output wire  o_ibus_cyc,
   output wire  o_dbus_cyc,
   output wire  o_cnt_en,
   output wire  o_cnt0,
   output wire  o_cnt_done,
   output wire  o_stage2,
   output wire  o_rd_en
);

   state_t           state;
   state_t           state_nxt;
   logic [CNT_W-1:0] cnt;

   assign o_cnt_en   = (state == ST_EXEC1) || (state == ST_EXEC2);
   assign o_cnt0     = o_cnt_en && (cnt == '0);
   assign o_cnt_done = o_cnt_en && (cnt == '1);
   assign o_stage2   = (state == ST_EXEC2);
   assign o_ibus_cyc = (state == ST_FETCH);
   assign o_dbus_cyc = (state == ST_MEM);

   // Only single-pass ops write rd
   assign o_rd_en    = (state == ST_EXEC1) && !i_two_stage;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: state_nxt = ST_FETCH;
         ST_FETCH: begin
            if (i_ibus_ack) begin
               state_nxt = ST_EXEC1;
            end
         end
         ST_EXEC1: begin
            if (o_cnt_done) begin
               if (!i_two_stage) begin
                  state_nxt = ST_FETCH;
               end else if (i_store) begin
                  state_nxt = ST_MEM;
               end else begin
                  state_nxt = ST_EXEC2;
               end
            end
         end
         // Hold the write until the bus answers
         ST_MEM: begin
            if (i_dbus_ack) begin
               state_nxt = ST_EXEC2;
            end
         end
         ST_EXEC2: begin
            if (o_cnt_done) begin
               state_nxt = ST_FETCH;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= ST_IDLE;
         cnt   <= '0;
      end else begin
         state <= state_nxt;
         cnt   <= o_cnt_en ? cnt + CNT_W'(1) : '0;
      end
   end

endmodule

`default_nettype wire

// ==== serv_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_decode import serv_pkg::*; (
   input  wire             clk,
   input  wire             i_rst_n,
   input  wire [XLEN-1:0]  i_ibus_rdt,
   input  wire             i_ibus_ack,
   output alu_op_t         o_alu_op,
   output wire             o_op_b_imm,
   output wire             o_two_stage,
   output wire             o_store,
   output wire             o_branch,
   output wire             o_bne,
   output wire             o_jal,
   output wire             o_lui,
   output wire             o_rd_sel_ctrl
);

   logic [6:0] opc_q;
   logic [2:0] funct3_q;
   logic       funct7_b5_q;
   opcode_t    opcode;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         opc_q       <= '0;
         funct3_q    <= '0;
         funct7_b5_q <= 1'b0;
      end else if (i_ibus_ack) begin
         opc_q       <= i_ibus_rdt[6:0];
         funct3_q    <= i_ibus_rdt[14:12];
         funct7_b5_q <= i_ibus_rdt[30];
      end
   end

   assign opcode = opcode_t'(opc_q);

   assign o_op_b_imm    = (opcode == OPC_OPIMM);
   assign o_store       = (opcode == OPC_STORE);
   assign o_branch      = (opcode == OPC_BRANCH);
   assign o_jal         = (opcode == OPC_JAL);
   assign o_lui         = (opcode == OPC_LUI);
   assign o_two_stage   = o_branch || o_store;
   assign o_bne         = o_branch && funct3_q[0];

   // Link value comes from the PC unit
   assign o_rd_sel_ctrl = o_jal;

   always_comb begin
      o_alu_op = ALU_ADD;
      if (o_branch) begin
         // Compare runs with the subtract setting
         o_alu_op = ALU_SUB;
      end else if ((opcode == OPC_OP) || (opcode == OPC_OPIMM)) begin
         case (funct3_q)
            3'b000: begin
               if ((opcode == OPC_OP) && funct7_b5_q) begin
                  o_alu_op = ALU_SUB;
               end else begin
                  o_alu_op = ALU_ADD;
               end
            end
            3'b100: o_alu_op = ALU_XOR;
            3'b110: o_alu_op = ALU_OR;
            3'b111: o_alu_op = ALU_AND;
            default: o_alu_op = ALU_ADD;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== serv_immdec.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_immdec import serv_pkg::*; (
   input  wire               clk,
   input  wire [XLEN-1:0]    i_ibus_rdt,
   input  wire               i_ibus_ack,
   input  wire               i_cnt_en,
   input  wire               i_opcode_u,
   input  wire               i_opcode_j,
   input  wire               i_opcode_b,
   input  wire               i_opcode_s,
   output wire               o_imm,
   output wire [REG_AW-1:0]  o_rs1_addr,
   output wire [REG_AW-1:0]  o_rs2_addr,
   output wire [REG_AW-1:0]  o_rd_addr
);

   logic [31:7]      ins_q;
   logic [XLEN-1:0]  imm_word;
   logic [4:0]       bit_ptr;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         ins_q   <= i_ibus_rdt[31:7];
         bit_ptr <= '0;
      end else if (i_cnt_en) begin
         bit_ptr <= bit_ptr + 5'd1;
      end
   end

   assign o_rs1_addr = ins_q[19:15];
   assign o_rs2_addr = ins_q[24:20];
   assign o_rd_addr  = ins_q[11:7];

   // Sign-extended immediate, type picked by the latched opcode
   always_comb begin
      if (i_opcode_u) begin
         imm_word = {ins_q[31:12], 12'b0};
      end else if (i_opcode_j) begin
         imm_word = {{12{ins_q[31]}}, ins_q[19:12], ins_q[20], ins_q[30:21], 1'b0};
      end else if (i_opcode_b) begin
         imm_word = {{20{ins_q[31]}}, ins_q[7], ins_q[30:25], ins_q[11:8], 1'b0};
      end else if (i_opcode_s) begin
         imm_word = {{21{ins_q[31]}}, ins_q[30:25], ins_q[11:7]};
      end else begin
         imm_word = {{21{ins_q[31]}}, ins_q[30:20]};
      end
   end

   // Pointer wraps after a pass so EXEC2 sees the same sequence
   assign o_imm = imm_word[bit_ptr];

endmodule

`default_nettype wire

// ==== serv_bufreg.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_bufreg import serv_pkg::*; (
   input  wire              clk,
   input  wire              i_cnt_en,
   input  wire              i_stage2,
   input  wire              i_store,
   input  wire              i_rs1,
   input  wire              i_rs2,
   input  wire              i_imm,
   output wire [XLEN-1:0]   o_dbus_adr,
   output wire [XLEN-1:0]   o_dbus_dat
);

   logic             en;
   logic             sum;
   logic             carry;
   logic [XLEN-1:0]  adr_q;
   logic [XLEN-1:0]  dat_q;

   assign en  = i_cnt_en && i_store && !i_stage2;
   assign sum = i_rs1 ^ i_imm ^ carry;

   // Carry falls back to zero between passes
   always_ff @(posedge clk) begin
      carry <= en && ((i_rs1 & i_imm) | (i_rs1 & carry) | (i_imm & carry));
   end

   // LSB first, so the word is complete after 32 shifts
   always_ff @(posedge clk) begin
      if (en) begin
         adr_q <= {sum, adr_q[XLEN-1:1]};
         dat_q <= {i_rs2, dat_q[XLEN-1:1]};
      end
   end

   assign o_dbus_adr = adr_q;
   assign o_dbus_dat = dat_q;

endmodule

`default_nettype wire

// ==== serv_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_ctrl import serv_pkg::*; #(
   parameter logic [XLEN-1:0] RESET_PC = '0
) (
   input  wire              clk,
   input  wire              i_rst_n,
   input  wire              i_cnt_en,
   input  wire              i_cnt0,
   input  wire              i_cnt_done,
   input  wire              i_stage2,
   input  wire              i_two_stage,
   input  wire              i_jal,
   input  wire              i_branch_taken,
   input  wire              i_imm,
   output wire [XLEN-1:0]   o_ibus_adr,
   output wire              o_rd
);

   logic [XLEN-1:0]  pc_q;
   logic             pc_en;
   logic             cnt1_q;
   logic             cnt2_q;
   logic             offset;
   logic             pc_carry;
   logic             link_carry;
   logic             pc_nxt;

   // PC moves in the last pass of every instruction
   assign pc_en  = i_cnt_en && !(i_two_stage ^ i_stage2);
   assign offset = (i_jal || (i_stage2 && i_branch_taken)) ? i_imm : cnt2_q;

   assign pc_nxt = pc_q[0] ^ offset ^ pc_carry;
   assign o_rd   = pc_q[0] ^ cnt2_q ^ link_carry;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q       <= RESET_PC;
         cnt1_q     <= 1'b0;
         cnt2_q     <= 1'b0;
         pc_carry   <= 1'b0;
         link_carry <= 1'b0;
      end else begin
         // Marks bit 2, the only set bit of the constant 4
         cnt1_q <= i_cnt0;
         cnt2_q <= cnt1_q;
         pc_carry <= pc_en && !i_cnt_done &&
                     ((pc_q[0] & offset) | (pc_q[0] & pc_carry) | (offset & pc_carry));
         link_carry <= pc_en && !i_cnt_done &&
                       ((pc_q[0] & cnt2_q) | (pc_q[0] & link_carry) | (cnt2_q & link_carry));
         if (pc_en) begin
            pc_q <= {pc_nxt, pc_q[XLEN-1:1]};
         end
      end
   end

   assign o_ibus_adr = pc_q;

endmodule

`default_nettype wire

// ==== serv_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_alu import serv_pkg::*; (
   input  wire      clk,
   input  wire      i_cnt_en,
   input  wire      i_cnt0,
   input  alu_op_t  i_alu_op,
   input  wire      i_op_b_imm,
   input  wire      i_bne,
   input  wire      i_rs1,
   input  wire      i_rs2,
   input  wire      i_imm,
   input  wire      i_lui,
   output logic     o_rd,
   output wire      o_branch_taken
);

   logic sub;
   logic op_b;
   logic b_inv;
   logic cin;
   logic sum;
   logic carry_q;
   logic eq_acc;
   logic cmp_q;
   logic bit_eq;

   assign sub    = (i_alu_op == ALU_SUB);
   assign op_b   = i_op_b_imm ? i_imm : i_rs2;
   assign b_inv  = op_b ^ sub;
   assign cin    = i_cnt0 ? sub : carry_q;
   assign sum    = i_rs1 ^ b_inv ^ cin;
   assign bit_eq = !(i_rs1 ^ op_b);

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_q <= (i_rs1 & b_inv) | (i_rs1 & cin) | (b_inv & cin);
         eq_acc  <= i_cnt0 ? bit_eq : (eq_acc & bit_eq);
         // Keep the result of the compare pass for the PC pass
         if (i_cnt0) begin
            cmp_q <= eq_acc;
         end
      end
   end

   assign o_branch_taken = sub && ((i_cnt0 ? eq_acc : cmp_q) ^ i_bne);

   always_comb begin
      case (i_alu_op)
         ALU_XOR: o_rd = i_rs1 ^ op_b;
         ALU_OR:  o_rd = i_rs1 | op_b;
         ALU_AND: o_rd = i_rs1 & op_b;
         default: o_rd = sum;
      endcase
      if (i_lui) begin
         o_rd = i_imm;
      end
   end

endmodule

`default_nettype wire

// ==== serv_rf_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_rf_ram import serv_pkg::*; (
   input  wire               clk,
   input  wire               i_cnt_en,
   input  wire               i_rd_en,
   input  wire               i_rd_sel_ctrl,
   input  wire               i_alu_rd,
   input  wire               i_ctrl_rd,
   input  wire [REG_AW-1:0]  i_rs1_addr,
   input  wire [REG_AW-1:0]  i_rs2_addr,
   input  wire [REG_AW-1:0]  i_rd_addr,
   output wire               o_rs1,
   output wire               o_rs2
);

   logic [XLEN-1:0] regs [0:(1<<REG_AW)-1];

   // Passes are always 32 counted cycles, so the pointer stays aligned
   logic [4:0]      bit_ptr = '0;
   logic            wr_bit;

   assign wr_bit = i_rd_sel_ctrl ? i_ctrl_rd : i_alu_rd;

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         bit_ptr <= bit_ptr + 5'd1;
      end
   end

   // x0 is never written
   always_ff @(posedge clk) begin
      if (i_cnt_en && i_rd_en && (i_rd_addr != '0)) begin
         regs[i_rd_addr][bit_ptr] <= wr_bit;
      end
   end

   // Reads of x0 return zero
   assign o_rs1 = (i_rs1_addr != '0) && regs[i_rs1_addr][bit_ptr];
   assign o_rs2 = (i_rs2_addr != '0) && regs[i_rs2_addr][bit_ptr];

endmodule

`default_nettype wire

// ==== serv_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module serv_top import serv_pkg::*; #(
   parameter logic [XLEN-1:0] RESET_PC = '0
) (
   input  wire              clk,
   input  wire              i_rst_n,
   output wire [XLEN-1:0]   o_ibus_adr,
   output wire              o_ibus_cyc,
   input  wire [XLEN-1:0]   i_ibus_rdt,
   input  wire              i_ibus_ack,
   output wire [XLEN-1:0]   o_dbus_adr,
   output wire [XLEN-1:0]   o_dbus_dat,
   output wire              o_dbus_cyc,
   input  wire              i_dbus_ack
);

   wire              cnt_en;
   wire              cnt0;
   wire              cnt_done;
   wire              stage2;
   wire              rd_en;

   alu_op_t          alu_op;
   wire              op_b_imm;
   wire              two_stage;
   wire              store;
   wire              branch;
   wire              bne;
   wire              jal;
   wire              lui;
   wire              rd_sel_ctrl;

   wire              imm;
   wire [REG_AW-1:0] rs1_addr;
   wire [REG_AW-1:0] rs2_addr;
   wire [REG_AW-1:0] rd_addr;

   wire              rs1;
   wire              rs2;
   wire              alu_rd;
   wire              ctrl_rd;
   wire              branch_taken;

   serv_state state_inst (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_ibus_ack   (i_ibus_ack),
      .i_dbus_ack   (i_dbus_ack),
      .i_two_stage  (two_stage),
      .i_store      (store),
      .o_ibus_cyc   (o_ibus_cyc),
      .o_dbus_cyc   (o_dbus_cyc),
      .o_cnt_en     (cnt_en),
      .o_cnt0       (cnt0),
      .o_cnt_done   (cnt_done),
      .o_stage2     (stage2),
      .o_rd_en      (rd_en)
   );

   serv_decode decode_inst (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_ibus_rdt    (i_ibus_rdt),
      .i_ibus_ack    (i_ibus_ack),
      .o_alu_op      (alu_op),
      .o_op_b_imm    (op_b_imm),
      .o_two_stage   (two_stage),
      .o_store       (store),
      .o_branch      (branch),
      .o_bne         (bne),
      .o_jal         (jal),
      .o_lui         (lui),
      .o_rd_sel_ctrl (rd_sel_ctrl)
   );

   serv_immdec immdec_inst (
      .clk         (clk),
      .i_ibus_rdt  (i_ibus_rdt),
      .i_ibus_ack  (i_ibus_ack),
      .i_cnt_en    (cnt_en),
      .i_opcode_u  (lui),
      .i_opcode_j  (jal),
      .i_opcode_b  (branch),
      .i_opcode_s  (store),
      .o_imm       (imm),
      .o_rs1_addr  (rs1_addr),
      .o_rs2_addr  (rs2_addr),
      .o_rd_addr   (rd_addr)
   );

   serv_bufreg bufreg_inst (
      .clk         (clk),
      .i_cnt_en    (cnt_en),
      .i_stage2    (stage2),
      .i_store     (store),
      .i_rs1       (rs1),
      .i_rs2       (rs2),
      .i_imm       (imm),
      .o_dbus_adr  (o_dbus_adr),
      .o_dbus_dat  (o_dbus_dat)
   );

   serv_ctrl #(
      .RESET_PC (RESET_PC)
   ) ctrl_inst (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_cnt_en       (cnt_en),
      .i_cnt0         (cnt0),
      .i_cnt_done     (cnt_done),
      .i_stage2       (stage2),
      .i_two_stage    (two_stage),
      .i_jal          (jal),
      .i_branch_taken (branch_taken),
      .i_imm          (imm),
      .o_ibus_adr     (o_ibus_adr),
      .o_rd           (ctrl_rd)
   );

   serv_alu alu_inst (
      .clk            (clk),
      .i_cnt_en       (cnt_en),
      .i_cnt0         (cnt0),
      .i_alu_op       (alu_op),
      .i_op_b_imm     (op_b_imm),
      .i_bne          (bne),
      .i_rs1          (rs1),
      .i_rs2          (rs2),
      .i_imm          (imm),
      .i_lui          (lui),
      .o_rd           (alu_rd),
      .o_branch_taken (branch_taken)
   );

   serv_rf_ram rf_ram_inst (
      .clk           (clk),
      .i_cnt_en      (cnt_en),
      .i_rd_en       (rd_en),
      .i_rd_sel_ctrl (rd_sel_ctrl),
      .i_alu_rd      (alu_rd),
      .i_ctrl_rd     (ctrl_rd),
      .i_rs1_addr    (rs1_addr),
      .i_rs2_addr    (rs2_addr),
      .i_rd_addr     (rd_addr),
      .o_rs1         (rs1),
      .o_rs2         (rs2)
   );

endmodule

`default_nettype wire

// ==== tb_serv_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_serv_top import serv_pkg::*; ();

   localparam logic [XLEN-1:0] RESET_PC   = 32'h0000_0100;
   localparam logic [XLEN-1:0] BASE       = 32'h8000_0000;
   localparam int              IMEM_WORDS = 64;
   localparam int              TIMEOUT    = 20000;

   logic              clk;
   logic              rst_n;
   logic [XLEN-1:0]   ibus_rdt = '0;
   logic              ibus_ack = 1'b0;
   logic              dbus_ack = 1'b0;
   wire  [XLEN-1:0]   ibus_adr;
   wire               ibus_cyc;
   wire  [XLEN-1:0]   dbus_adr;
   wire  [XLEN-1:0]   dbus_dat;
   wire               dbus_cyc;

   logic [XLEN-1:0]   imem [0:IMEM_WORDS-1];
   int                prog_len = 0;
   bit                slow = 1'b0;
   logic [XLEN-1:0]   fetch_q [$];
   logic [XLEN-1:0]   st_adr_q [$];
   logic [XLEN-1:0]   st_dat_q [$];
   logic [XLEN-1:0]   exp_adr_q [$];
   logic [XLEN-1:0]   exp_dat_q [$];
   logic [XLEN-1:0]   fetch_pc_q [$];
   logic [XLEN-1:0]   next_pc_q [$];
   bit                ibus_busy = 1'b0;
   int                ibus_wait = 0;
   bit                dbus_busy = 1'b0;
   int                dbus_wait = 0;
   logic [XLEN-1:0]   held_adr = '0;
   logic [XLEN-1:0]   held_dat = '0;

   serv_top #(
      .RESET_PC (RESET_PC)
   ) serv_top_inst (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .o_dbus_cyc (dbus_cyc),
      .i_dbus_ack (dbus_ack)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic fail_now(string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
      if (got !== exp) begin
         fail_now($sformatf("ERR %s got %08h expected %08h", name, got, exp));
      end
   endtask

   function automatic int ack_delay();
      return slow ? 6 + int'($urandom % 15) : int'($urandom % 4);
   endfunction

   // RV32I encodings
   function automatic logic [31:0] i_type(int f3, int rd, int rs1, int imm);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OPIMM};
   endfunction

   function automatic logic [31:0] r_type(int f7, int f3, int rd, int rs1, int rs2);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
   endfunction

   function automatic logic [31:0] u_type(int rd, int u);
      return {u[19:0], rd[4:0], OPC_LUI};
   endfunction

   function automatic logic [31:0] s_type(int rs2, int rs1, int off);
      return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], OPC_STORE};
   endfunction

   function automatic logic [31:0] b_type(int f3, int rs1, int rs2, int off);
      return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
   endfunction

   function automatic logic [31:0] j_type(int rd, int off);
      return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
   endfunction

   function automatic logic [31:0] sext12(int v);
      return {{20{v[11]}}, v[11:0]};
   endfunction

   function automatic logic [31:0] fetch_after(logic [31:0] adr);
      for (int k = 0; k + 1 < fetch_q.size(); k++) begin
         if (fetch_q[k] == adr) begin
            return fetch_q[k+1];
         end
      end
      return 32'hffff_ffff;
   endfunction

   task automatic emit(logic [31:0] instr);
      imem[prog_len[5:0]] = instr;
      prog_len++;
   endtask

   task automatic expect_store(logic [31:0] adr, logic [31:0] dat);
      exp_adr_q.push_back(adr);
      exp_dat_q.push_back(dat);
   endtask

   task automatic expect_next_fetch(logic [31:0] pc, logic [31:0] next);
      fetch_pc_q.push_back(pc);
      next_pc_q.push_back(next);
   endtask

   // Instruction memory with a random ack delay
   always @(negedge clk) begin
      logic [XLEN-1:0] word;
      if (!rst_n) begin
         ibus_ack = 1'b0;
         ibus_busy = 1'b0;
         fetch_q.delete();
      end else if (ibus_ack) begin
         ibus_ack = 1'b0;
         ibus_busy = 1'b0;
      end else if (ibus_cyc) begin
         if (!ibus_busy) begin
            ibus_busy = 1'b1;
            ibus_wait = ack_delay();
         end
         if (ibus_wait > 0) begin
            ibus_wait--;
         end else begin
            word = ibus_adr - RESET_PC;
            if (word[1:0] != 2'b00 || (word >> 2) >= prog_len) begin
               fail_now("instruction fetch outside the loaded program");
            end else begin
               ibus_rdt = imem[word[7:2]];
               ibus_ack = 1'b1;
               fetch_q.push_back(ibus_adr);
            end
         end
      end
   end

   // Data bus responder that logs every write
   always @(negedge clk) begin
      if (!rst_n) begin
         dbus_ack = 1'b0;
         dbus_busy = 1'b0;
         st_adr_q.delete();
         st_dat_q.delete();
      end else if (dbus_ack) begin
         dbus_ack = 1'b0;
         dbus_busy = 1'b0;
      end else if (dbus_cyc) begin
         if (!dbus_busy) begin
            dbus_busy = 1'b1;
            dbus_wait = ack_delay();
            held_adr = dbus_adr;
            held_dat = dbus_dat;
         end
         // Request must hold still until acked
         check_eq("o_dbus_adr", dbus_adr, held_adr);
         check_eq("o_dbus_dat", dbus_dat, held_dat);
         if (dbus_wait > 0) begin
            dbus_wait--;
         end else begin
            dbus_ack = 1'b1;
            st_adr_q.push_back(dbus_adr);
            st_dat_q.push_back(dbus_dat);
         end
      end
   end

   task automatic hold_reset();
      int cycles;
      cycles = 0;
      // Stop the core between instructions so the serial bit pointers stay aligned
      if (rst_n) begin
         do begin
            @(negedge clk);
            cycles++;
         end while (!ibus_cyc && cycles < TIMEOUT);
         if (!ibus_cyc) begin
            fail_now("timeout waiting for an instruction fetch before reset");
         end
      end
      rst_n = 1'b0;
      prog_len = 0;
      exp_adr_q.delete();
      exp_dat_q.delete();
      fetch_pc_q.delete();
      next_pc_q.delete();
      repeat (8) begin
         @(negedge clk);
         check_eq("o_ibus_cyc", 32'(ibus_cyc), 32'd0);
         check_eq("o_dbus_cyc", 32'(dbus_cyc), 32'd0);
      end
   endtask

   task automatic run_and_compare();
      int cycles;
      rst_n = 1'b1;
      cycles = 0;
      while (!ibus_cyc && cycles < 2) begin
         @(negedge clk);
         cycles++;
      end
      if (!ibus_cyc) begin
         fail_now("first instruction fetch did not start after reset");
      end
      check_eq("o_ibus_adr", ibus_adr, RESET_PC);
      cycles = 0;
      while (st_adr_q.size() < exp_adr_q.size() && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (st_adr_q.size() < exp_adr_q.size()) begin
         fail_now("timeout waiting for the expected data bus writes");
      end
      foreach (exp_adr_q[k]) begin
         check_eq("o_dbus_adr", st_adr_q[k], exp_adr_q[k]);
         check_eq("o_dbus_dat", st_dat_q[k], exp_dat_q[k]);
      end
      foreach (fetch_pc_q[k]) begin
         check_eq("o_ibus_adr", fetch_after(fetch_pc_q[k]), next_pc_q[k]);
      end
   endtask

   task automatic imm_and_lui_ops();
      int u;
      int ia;
      int ix;
      int io;
      int iand;
      logic [31:0] v;
      hold_reset();
      u = $urandom;
      ia = $urandom;
      ix = $urandom;
      io = $urandom;
      iand = $urandom;
      v = {u[19:0], 12'h000};
      emit(u_type(31, 'h80000));
      emit(u_type(1, u));
      emit(s_type(1, 31, 0));
      expect_store(BASE, v);
      emit(i_type(0, 2, 1, ia));
      emit(s_type(2, 31, 4));
      expect_store(BASE + 4, v + sext12(ia));
      emit(i_type(4, 3, 1, ix));
      emit(s_type(3, 31, 8));
      expect_store(BASE + 8, v ^ sext12(ix));
      emit(i_type(6, 4, 1, io));
      emit(s_type(4, 31, 12));
      expect_store(BASE + 12, v | sext12(io));
      // Negative store offset
      emit(i_type(7, 5, 1, iand));
      emit(s_type(5, 31, -8));
      expect_store(BASE - 8, v & sext12(iand));
      emit(j_type(0, 0));
      run_and_compare();
   endtask

   task automatic reg_reg_ops();
      int ua;
      int ia;
      int ub;
      int ib;
      logic [31:0] a;
      logic [31:0] b;
      hold_reset();
      ua = $urandom;
      ia = $urandom;
      ub = $urandom;
      ib = $urandom;
      a = {ua[19:0], 12'h000} + sext12(ia);
      b = {ub[19:0], 12'h000} + sext12(ib);
      emit(u_type(31, 'h80000));
      emit(u_type(1, ua));
      emit(i_type(0, 1, 1, ia));
      emit(u_type(2, ub));
      emit(i_type(0, 2, 2, ib));
      emit(r_type(0, 0, 3, 1, 2));
      emit(s_type(3, 31, 16));
      expect_store(BASE + 16, a + b);
      emit(r_type('h20, 0, 4, 1, 2));
      emit(s_type(4, 31, 20));
      expect_store(BASE + 20, a - b);
      emit(r_type(0, 4, 5, 1, 2));
      emit(s_type(5, 31, 24));
      expect_store(BASE + 24, a ^ b);
      emit(r_type(0, 6, 6, 1, 2));
      emit(s_type(6, 31, 28));
      expect_store(BASE + 28, a | b);
      emit(r_type(0, 7, 7, 1, 2));
      emit(s_type(7, 31, 32));
      expect_store(BASE + 32, a & b);
      emit(j_type(0, 0));
      run_and_compare();
   endtask

   // Compares x1 with rs2, then stores a marker for the path taken
   task automatic branch_block(int f3, int rs2, int a, int v, int k);
      logic [31:0] pc;
      bit taken;
      pc = RESET_PC + 4 * prog_len;
      taken = (f3 == 1) ? (a != v) : (a == v);
      emit(b_type(f3, 1, rs2, 12));
      emit(i_type(0, 9, 0, 'h200 + k));
      emit(j_type(0, 8));
      emit(i_type(0, 9, 0, 'h100 + k));
      emit(s_type(9, 31, 4 * k));
      expect_store(BASE + 4 * k, taken ? 'h100 + k : 'h200 + k);
      expect_next_fetch(pc, taken ? pc + 12 : pc + 4);
   endtask

   task automatic branch_outcomes();
      int a;
      int b;
      hold_reset();
      a = int'($urandom % 2048);
      b = a ^ (1 << ($urandom % 11));
      emit(u_type(31, 'h80000));
      emit(i_type(0, 1, 0, a));
      emit(i_type(0, 2, 0, a));
      emit(i_type(0, 3, 0, b));
      branch_block(0, 2, a, a, 0);
      branch_block(0, 3, a, b, 1);
      branch_block(1, 3, a, b, 2);
      branch_block(1, 2, a, a, 3);
      emit(j_type(0, 0));
      run_and_compare();
   endtask

   task automatic jal_and_x0();
      hold_reset();
      emit(u_type(31, 'h80000));
      emit(j_type(1, 8));
      emit(i_type(0, 1, 0, 'h7ff));
      emit(s_type(1, 31, 0));
      emit(i_type(0, 0, 0, 'h5a5));
      emit(u_type(0, 'hfffff));
      emit(s_type(0, 31, 4));
      emit(j_type(0, 12));
      emit(s_type(2, 31, 8));
      emit(j_type(0, 8));
      // Backward jump with link
      emit(j_type(2, -8));
      emit(j_type(0, 0));
      expect_store(BASE, RESET_PC + 8);
      expect_store(BASE + 4, 32'd0);
      expect_store(BASE + 8, RESET_PC + 44);
      expect_next_fetch(RESET_PC + 4, RESET_PC + 12);
      expect_next_fetch(RESET_PC + 40, RESET_PC + 32);
      run_and_compare();
   endtask

   task automatic slow_bus_rerun();
      slow = 1'b1;
      imm_and_lui_ops();
      reg_reg_ops();
      slow = 1'b0;
   endtask

   initial begin
      logic [31:0] seed_out;
      rst_n = 1'b0;
      seed_out = $urandom(32'hf73f0392);
      imm_and_lui_ops();
      reg_reg_ops();
      branch_outcomes();
      jal_and_x0();
      slow_bus_rerun();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
serv_pkg.sv
serv_state.sv
serv_decode.sv
serv_immdec.sv
serv_bufreg.sv
serv_ctrl.sv
serv_alu.sv
serv_rf_ram.sv
serv_top.sv
tb_serv_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module tb_serv_top -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1
